//--- vlog.f
src/axi_wr_pkg.sv
src/axi_burst_planner.sv
src/axi_data_aligner.sv
src/axi_simple_wr_bridge.sv
src/axi_wr_sub.sv
dv/axi_mem_slave.sv
dv/tb_axi_wr.sv

//--- dv/tb_axi_wr.sv
`timescale 1ns/10ps
`default_nettype none

module tb_axi_wr;

   localparam int DATA_W    = 32;
   localparam int MAX_BEATS = 16;
   localparam int BYTES     = DATA_W / 8;
   localparam int NUM_REQ   = 40;
   localparam int MEM_BYTES = 16384;
   localparam int MAX_LEN   = 200;

   localparam logic [3:0] EXP_CACHE = 4'b0010;   // Normal non-cacheable non-bufferable
   localparam logic [2:0] EXP_PROT  = 3'b010;    // Unprivileged non-secure data

   logic                clk_i;
   logic                rst_i;
   logic                m_wvalid_i;
   axi_wr_pkg::addr_t   m_waddr_i;
   axi_wr_pkg::blen_t   m_wlen_i;
   logic [DATA_W-1:0]   m_wdata_i;
   logic                m_wready_o;
   logic                m_wlast_o;
   axi_wr_pkg::addr_t   axi_awaddr_o;
   axi_wr_pkg::axlen_t  axi_awlen_o;
   logic [2:0]          axi_awsize_o;
   logic [1:0]          axi_awburst_o;
   logic [3:0]          axi_awcache_o;
   logic [2:0]          axi_awprot_o;
   logic                axi_awvalid_o;
   logic                axi_awready_i;
   logic [DATA_W-1:0]   axi_wdata_o;
   logic [BYTES-1:0]    axi_wstrb_o;
   logic                axi_wlast_o;
   logic                axi_wvalid_o;
   logic                axi_wready_i;
   logic [1:0]          axi_bresp_i;
   logic                axi_bvalid_i;
   logic                axi_bready_o;
   logic                aw_stall;
   logic                w_stall;
   logic                slave_err;

   logic [31:0] lfsr_q = 32'hf5c25341;
   logic [7:0]  ref_mem [0:MEM_BYTES-1];
   logic [7:0]  req_bytes [0:MAX_LEN-1];
   int          cur_len = 0;
   int          exp_words = 0;
   int          exp_beats = 0;
   int          words_seen = 0;   // Requester words taken in this request
   int          beats_seen = 0;
   logic        took_word = 1'b0;
   logic        took_beat = 1'b0;

   axi_wr_sub #(.DATA_W(DATA_W), .MAX_BEATS(MAX_BEATS)) dut0 (.*);

   axi_mem_slave #(
      .DATA_W   (DATA_W),
      .MAX_BEATS(MAX_BEATS),
      .MEM_BYTES(MEM_BYTES)
   ) slave0 (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .awaddr_i  (axi_awaddr_o),
      .awlen_i   (axi_awlen_o),
      .awsize_i  (axi_awsize_o),
      .awburst_i (axi_awburst_o),
      .awvalid_i (axi_awvalid_o),
      .awready_o (axi_awready_i),
      .wdata_i   (axi_wdata_o),
      .wstrb_i   (axi_wstrb_o),
      .wlast_i   (axi_wlast_o),
      .wvalid_i  (axi_wvalid_o),
      .wready_o  (axi_wready_i),
      .bresp_o   (axi_bresp_i),
      .bvalid_o  (axi_bvalid_i),
      .bready_i  (axi_bready_o),
      .aw_stall_i(aw_stall),
      .w_stall_i (w_stall),
      .err_o     (slave_err)
   );

   initial begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   always @(posedge clk_i) begin
      took_word <= m_wvalid_i && m_wready_o;
      took_beat <= axi_wvalid_o && axi_wready_i;
   end

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32 22 2 1
   endfunction

   function automatic int unsigned rand_bits(input int nbits);
      int unsigned v;
      int          k;
      v = 0;
      for (k = 0; k < nbits; k++) begin
         lfsr_q = lfsr_step(lfsr_q);
         v      = (v << 1) | lfsr_q[0];
      end
      return v;
   endfunction

   function automatic logic [7:0] bg_byte(input int a);
      return 8'(a ^ (a >> 8) ^ 'h3c);
   endfunction

   // Request bytes packed from lane 0
   function automatic logic [DATA_W-1:0] pack_word(input int k);
      logic [DATA_W-1:0] w;
      int                b;
      w = '0;
      for (b = 0; b < BYTES; b++) begin
         if (k * BYTES + b < cur_len) w[8*b +: 8] = req_bytes[k * BYTES + b];
      end
      return w;
   endfunction

   task automatic fail_stop(input string why);
      $display("%s", why);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic next_cycle();
      @(negedge clk_i);
      if (took_word) words_seen++;
      if (took_beat) beats_seen++;
      aw_stall = (rand_bits(2) == 0);
      w_stall  = (rand_bits(2) == 0);
   endtask

   task automatic compare_memory();
      int a;
      for (a = 0; a < MEM_BYTES; a++) begin
         assert (slave0.mem[a] == ref_mem[a])
            else fail_stop($sformatf("[FAIL] %0t: memory byte %h is %h, expected %h",
                                     $time, a, slave0.mem[a], ref_mem[a]));
      end
   endtask

   task automatic run_request();
      int unsigned addr;
      int unsigned page;
      int unsigned len;
      int          i;
      repeat (rand_bits(2)) next_cycle();
      if (rand_bits(2) == 0) begin
         page = rand_bits(2) % 3 + 1;
         addr = page * 4096 - 1 - rand_bits(6);   // Just below a page end
      end else begin
         addr = rand_bits(14) % (MEM_BYTES - MAX_LEN);
      end
      len = rand_bits(8) % MAX_LEN + 1;
      for (i = 0; i < len; i++) begin
         req_bytes[i]      = 8'(rand_bits(8));
         ref_mem[addr + i] = req_bytes[i];
      end
      cur_len    = len;
      exp_words  = (len + BYTES - 1) / BYTES;
      exp_beats  = (addr % BYTES + len + BYTES - 1) / BYTES;
      words_seen = 0;
      beats_seen = 0;
      m_waddr_i  = addr;
      m_wlen_i   = 16'(len);
      m_wdata_i  = pack_word(0);
      m_wvalid_i = 1'b1;
      while (words_seen < exp_words || beats_seen < exp_beats) begin
         next_cycle();
         if (words_seen == exp_words) m_wvalid_i = 1'b0;   // Data held for a flush beat
         else m_wdata_i = pack_word(words_seen);
      end
      compare_memory();
   endtask

   a_reset_quiet : assert property (@(posedge clk_i)
      rst_i |=> !axi_awvalid_o && !axi_wvalid_o && !m_wready_o && !m_wlast_o)
      else fail_stop($sformatf("[FAIL] %0t: handshake output high after reset", $time));

   a_aw_stable : assert property (@(posedge clk_i) disable iff (rst_i)
      axi_awvalid_o && !axi_awready_i |=>
         axi_awvalid_o && $stable(axi_awaddr_o) && $stable(axi_awlen_o))
      else fail_stop($sformatf("[FAIL] %0t: AW dropped or changed before awready", $time));

   a_aw_fixed : assert property (@(posedge clk_i) disable iff (rst_i)
      axi_awvalid_o |-> axi_awcache_o == EXP_CACHE && axi_awprot_o == EXP_PROT)
      else fail_stop($sformatf("[FAIL] %0t: AW cache %h prot %h", $time,
                               $sampled(axi_awcache_o), $sampled(axi_awprot_o)));

   a_bready_high : assert property (@(posedge clk_i) disable iff (rst_i)
      axi_bready_o)
      else fail_stop($sformatf("[FAIL] %0t: bready is low", $time));

   a_w_stable : assert property (@(posedge clk_i) disable iff (rst_i)
      axi_wvalid_o && !axi_wready_i |=> axi_wvalid_o && $stable(axi_wdata_o)
         && $stable(axi_wstrb_o) && $stable(axi_wlast_o))
      else fail_stop($sformatf("[FAIL] %0t: W dropped or changed before wready", $time));

   a_beat_total : assert property (@(posedge clk_i) disable iff (rst_i)
      axi_wvalid_o |-> beats_seen < exp_beats)
      else fail_stop($sformatf("[FAIL] %0t: more W beats than %0d", $time, exp_beats));

   a_mlast_pos : assert property (@(posedge clk_i) disable iff (rst_i)
      m_wvalid_i && m_wready_o |-> m_wlast_o == (words_seen == exp_words - 1))
      else fail_stop($sformatf("[FAIL] %0t: m_wlast_o wrong on word %0d of %0d",
                               $time, words_seen + 1, exp_words));

   a_no_extra_ready : assert property (@(posedge clk_i) disable iff (rst_i)
      m_wready_o |-> words_seen < exp_words)
      else fail_stop($sformatf("[FAIL] %0t: m_wready_o after the last word", $time));

   initial begin
      int a;
      int n;
      rst_i      = 1'b1;
      m_wvalid_i = 1'b0;
      m_waddr_i  = '0;
      m_wlen_i   = '0;
      m_wdata_i  = '0;
      aw_stall   = 1'b1;
      w_stall    = 1'b1;
      for (a = 0; a < MEM_BYTES; a++) begin
         ref_mem[a]    = bg_byte(a);
         slave0.mem[a] = bg_byte(a);
      end
      repeat (16) @(negedge clk_i);
      rst_i = 1'b0;
      for (n = 0; n < NUM_REQ; n++) begin
         run_request();
      end
      $display("Simulation finished: PASS");
      $finish;
   end

   initial begin
      @(posedge slave_err);
      fail_stop("The AXI slave model detected a protocol error");
   end

   // Reset plus 400 cycles per request
   initial begin
      repeat (16 + NUM_REQ * 400) @(posedge clk_i);
      fail_stop("Timeout: the write bridge stopped making progress and the run hung");
   end

endmodule

`default_nettype wire

//--- dv/axi_mem_slave.sv
`timescale 1ns/10ps
`default_nettype none

module axi_mem_slave #(
   parameter int DATA_W    = 32,
   parameter int MAX_BEATS = 16,
   parameter int MEM_BYTES = 16384
) (
   input  wire                 clk_i,
   input  wire                 rst_i,
   input  wire [31:0]          awaddr_i,
   input  wire [7:0]           awlen_i,
   input  wire [2:0]           awsize_i,
   input  wire [1:0]           awburst_i,
   input  wire                 awvalid_i,
   output logic                awready_o,
   input  wire [DATA_W-1:0]    wdata_i,
   input  wire [DATA_W/8-1:0]  wstrb_i,
   input  wire                 wlast_i,
   input  wire                 wvalid_i,
   output logic                wready_o,
   output logic [1:0]          bresp_o,
   output logic                bvalid_o,
   input  wire                 bready_i,
   input  wire                 aw_stall_i,
   input  wire                 w_stall_i,
   output logic                err_o
);

   localparam int BYTES = DATA_W / 8;

   logic [7:0]  mem [0:MEM_BYTES-1];   // Background filled from outside
   logic        active;                // Burst accepted, W beats pending
   logic [31:0] addr_q;
   logic [7:0]  len_q;
   logic [7:0]  beat_q;
   logic        aw_hs;
   logic        w_hs;

   assign aw_hs     = awvalid_i && awready_o;
   assign w_hs      = wvalid_i && wready_o;
   assign awready_o = !active && !aw_stall_i;   // One burst at a time
   assign wready_o  = active && !w_stall_i;
   assign bresp_o   = 2'b00;

   initial err_o = 1'b0;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         active   <= 1'b0;
         addr_q   <= '0;
         len_q    <= '0;
         beat_q   <= '0;
         bvalid_o <= 1'b0;
      end else begin
         if (bvalid_o && bready_i) bvalid_o <= 1'b0;
         if (aw_hs) begin
            active <= 1'b1;
            addr_q <= awaddr_i;
            len_q  <= awlen_i;
            beat_q <= '0;
         end
         if (w_hs) begin
            addr_q <= addr_q + 32'(BYTES);
            beat_q <= beat_q + 8'd1;
            if (wlast_i) begin
               active   <= 1'b0;
               bvalid_o <= 1'b1;
            end
         end
      end
   end

   always @(posedge clk_i) begin : mem_write
      int b;
      if (!rst_i && w_hs) begin
         for (b = 0; b < BYTES; b++) begin
            if (wstrb_i[b]) mem[(int'(addr_q) + b) % MEM_BYTES] <= wdata_i[8*b +: 8];
         end
      end
   end

   a_aw_attr : assert property (@(posedge clk_i) disable iff (rst_i)
      aw_hs |-> awsize_i == 3'($clog2(BYTES)) && awburst_i == 2'b01
                && int'(awlen_i) + 1 <= MAX_BEATS)
      else begin
         $display("[FAIL] %0t: AW size %0d burst %0d len %0d", $time,
                  $sampled(awsize_i), $sampled(awburst_i), $sampled(awlen_i));
         err_o = 1'b1;
      end

   // Whole burst inside one 4 KB page
   a_aw_page : assert property (@(posedge clk_i) disable iff (rst_i)
      aw_hs |-> int'(awaddr_i[11:0]) + (int'(awlen_i) + 1) * BYTES <= 4096)
      else begin
         $display("[FAIL] %0t: burst at %h crosses a 4 KB page", $time, $sampled(awaddr_i));
         err_o = 1'b1;
      end

   a_wlast_pos : assert property (@(posedge clk_i) disable iff (rst_i)
      w_hs |-> wlast_i == (beat_q == len_q))
      else begin
         $display("[FAIL] %0t: wlast %0b on beat %0d of %0d", $time, $sampled(wlast_i),
                  $sampled(beat_q) + 1, $sampled(len_q) + 1);
         err_o = 1'b1;
      end

endmodule

`default_nettype wire

//--- src/axi_wr_sub.sv
`timescale 1ns/10ps
`default_nettype none

module axi_wr_sub #(
   parameter int DATA_W    = 32,
   parameter int MAX_BEATS = 16
) (
   input  wire                     clk_i,
   input  wire                     rst_i,
   input  wire                     m_wvalid_i,
   input  wire axi_wr_pkg::addr_t  m_waddr_i,
   input  wire axi_wr_pkg::blen_t  m_wlen_i,
   input  wire [DATA_W-1:0]        m_wdata_i,
   output logic                    m_wready_o,
   output logic                    m_wlast_o,
   output axi_wr_pkg::addr_t       axi_awaddr_o,
   output axi_wr_pkg::axlen_t      axi_awlen_o,
   output logic [2:0]              axi_awsize_o,
   output logic [1:0]              axi_awburst_o,
   output logic [3:0]              axi_awcache_o,
   output logic [2:0]              axi_awprot_o,
   output logic                    axi_awvalid_o,
   input  wire                     axi_awready_i,
   output logic [DATA_W-1:0]       axi_wdata_o,
   output logic [DATA_W/8-1:0]     axi_wstrb_o,
   output logic                    axi_wlast_o,
   output logic                    axi_wvalid_o,
   input  wire                     axi_wready_i,
   input  wire [1:0]               axi_bresp_i,
   input  wire                     axi_bvalid_i,
   output logic                    axi_bready_o
);

   axi_simple_wr_bridge #(
      .DATA_W   (DATA_W),
      .MAX_BEATS(MAX_BEATS)
   ) u_bridge (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .m_wvalid_i   (m_wvalid_i),
      .m_waddr_i    (m_waddr_i),
      .m_wlen_i     (m_wlen_i),
      .m_wdata_i    (m_wdata_i),
      .m_wready_o   (m_wready_o),
      .m_wlast_o    (m_wlast_o),
      .axi_awaddr_o (axi_awaddr_o),
      .axi_awlen_o  (axi_awlen_o),
      .axi_awsize_o (axi_awsize_o),
      .axi_awburst_o(axi_awburst_o),
      .axi_awcache_o(axi_awcache_o),
      .axi_awprot_o (axi_awprot_o),
      .axi_awvalid_o(axi_awvalid_o),
      .axi_awready_i(axi_awready_i),
      .axi_wdata_o  (axi_wdata_o),
      .axi_wstrb_o  (axi_wstrb_o),
      .axi_wlast_o  (axi_wlast_o),
      .axi_wvalid_o (axi_wvalid_o),
      .axi_wready_i (axi_wready_i),
      .axi_bresp_i  (axi_bresp_i),
      .axi_bvalid_i (axi_bvalid_i),
      .axi_bready_o (axi_bready_o)
   );

endmodule

`default_nettype wire

//--- src/axi_simple_wr_bridge.sv
`timescale 1ns/10ps
`default_nettype none

module axi_simple_wr_bridge #(
   parameter int DATA_W    = 32,
   parameter int MAX_BEATS = 16
) (
   input  wire                     clk_i,
   input  wire                     rst_i,
   input  wire                     m_wvalid_i,
   input  wire axi_wr_pkg::addr_t  m_waddr_i,
   input  wire axi_wr_pkg::blen_t  m_wlen_i,
   input  wire [DATA_W-1:0]        m_wdata_i,
   output logic                    m_wready_o,
   output logic                    m_wlast_o,
   output axi_wr_pkg::addr_t       axi_awaddr_o,
   output axi_wr_pkg::axlen_t      axi_awlen_o,
   output logic [2:0]              axi_awsize_o,
   output logic [1:0]              axi_awburst_o,
   output logic [3:0]              axi_awcache_o,
   output logic [2:0]              axi_awprot_o,
   output logic                    axi_awvalid_o,
   input  wire                     axi_awready_i,
   output logic [DATA_W-1:0]       axi_wdata_o,
   output logic [DATA_W/8-1:0]     axi_wstrb_o,
   output logic                    axi_wlast_o,
   output logic                    axi_wvalid_o,
   input  wire                     axi_wready_i,
   input  wire [1:0]               axi_bresp_i,
   input  wire                     axi_bvalid_i,
   output logic                    axi_bready_o
);

   localparam int BYTES = DATA_W / 8;
   localparam int OFF_W = $clog2(BYTES);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_PLAN,
      ST_ADDR,
      ST_DATA
   } state_t;

   state_t               state;
   logic [OFF_W-1:0]     offset_q;
   axi_wr_pkg::axlen_t   blen_q;      // Length of the burst on W
   axi_wr_pkg::axlen_t   beat_cnt;    // Beat within burst
   axi_wr_pkg::cnt_t     total_cnt;   // Beats of the request so far
   axi_wr_pkg::cnt_t     words_cnt;   // Requester words accepted
   axi_wr_pkg::cnt_t     words_q;
   logic                 last_q;      // Burst on W is the final one
   logic                 nxt_last_q;

   logic                 start;
   logic                 aw_hs;
   logic                 w_hs;
   logic                 take;
   logic                 flush;
   logic                 burst_end;
   logic [BYTES-1:0]     lo_strb;
   logic [BYTES-1:0]     hi_strb;

   axi_wr_pkg::addr_t    burst_addr;
   axi_wr_pkg::axlen_t   burst_len;
   logic [BYTES-1:0]     first_strb;
   logic [BYTES-1:0]     final_strb;
   axi_wr_pkg::cnt_t     words;
   logic                 last_burst;
   logic                 last_burst_next;

   assign start = (state == ST_IDLE) && m_wvalid_i;
   assign aw_hs = axi_awvalid_o && axi_awready_i;
   assign w_hs  = axi_wvalid_o && axi_wready_i;
   assign take  = m_wvalid_i && m_wready_o;
   assign flush = (words_cnt == words_q);  // All words in, only leftover bytes remain

   axi_burst_planner #(
      .DATA_W   (DATA_W),
      .MAX_BEATS(MAX_BEATS)
   ) u_planner (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .addr_i           (m_waddr_i),
      .len_i            (m_wlen_i),
      .start_i          (start),
      .burst_accept_i   (aw_hs),
      .burst_addr_o     (burst_addr),
      .burst_len_o      (burst_len),
      .first_strb_o     (first_strb),
      .final_strb_o     (final_strb),
      .words_o          (words),
      .last_burst_o     (last_burst),
      .last_burst_next_o(last_burst_next)
   );

   axi_data_aligner #(
      .DATA_W(DATA_W)
   ) u_aligner (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .offset_i(offset_q),
      .data_i  (m_wdata_i),
      .take_i  (take),
      .data_o  (axi_wdata_o)
   );

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state      <= ST_IDLE;
         offset_q   <= '0;
         blen_q     <= '0;
         beat_cnt   <= '0;
         total_cnt  <= '0;
         words_cnt  <= '0;
         words_q    <= '0;
         last_q     <= 1'b0;
         nxt_last_q <= 1'b0;
      end else begin
         if (take) words_cnt <= words_cnt + axi_wr_pkg::cnt_t'(1);
         case (state)
            ST_IDLE: begin
               if (start) begin
                  offset_q  <= m_waddr_i[OFF_W-1:0];
                  words_cnt <= '0;
                  total_cnt <= '0;
                  state     <= ST_PLAN;
               end
            end
            ST_PLAN: begin  // Planner result valid now
               words_q <= words;
               last_q  <= last_burst;
               state   <= ST_ADDR;
            end
            ST_ADDR: begin
               if (aw_hs) begin
                  blen_q     <= burst_len;
                  nxt_last_q <= last_burst_next; // Planner moves on after this
                  beat_cnt   <= '0;
                  state      <= ST_DATA;
               end
            end
            ST_DATA: begin
               if (w_hs) begin
                  beat_cnt  <= beat_cnt + axi_wr_pkg::axlen_t'(1);
                  total_cnt <= total_cnt + axi_wr_pkg::cnt_t'(1);
                  if (burst_end) begin
                     if (last_q) begin
                        state <= ST_IDLE;
                     end else begin
                        last_q <= nxt_last_q;
                        state  <= ST_ADDR;
                     end
                  end
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   assign burst_end = (beat_cnt == blen_q);

   // First and final strobes overlap on a single-beat request
   assign lo_strb     = (total_cnt == '0) ? first_strb : {BYTES{1'b1}};
   assign hi_strb     = (last_q && burst_end) ? final_strb : {BYTES{1'b1}};
   assign axi_wstrb_o = lo_strb & hi_strb;

   assign axi_wvalid_o = (state == ST_DATA) && (flush || m_wvalid_i);
   assign axi_wlast_o  = axi_wvalid_o && burst_end;
   assign m_wready_o   = (state == ST_DATA) && !flush && axi_wready_i;
   assign m_wlast_o    = m_wready_o && (words_cnt == words_q - axi_wr_pkg::cnt_t'(1));

   assign axi_awvalid_o = (state == ST_ADDR);
   assign axi_awaddr_o  = burst_addr;
   assign axi_awlen_o   = burst_len;
   assign axi_awsize_o  = axi_wr_pkg::axsize_enc(DATA_W);
   assign axi_awburst_o = axi_wr_pkg::AXI_BURST_INCR;
   assign axi_awcache_o = axi_wr_pkg::AXI_CACHE_DEF;
   assign axi_awprot_o  = axi_wr_pkg::AXI_PROT_DEF;
   assign axi_bready_o  = 1'b1;  // Responses are dropped

   a_aw_hold : assert property (@(posedge clk_i) disable iff (rst_i)
      axi_awvalid_o && !axi_awready_i |=>
         axi_awvalid_o && $stable(axi_awaddr_o) && $stable(axi_awlen_o))
      else $error("awvalid or AW payload changed before awready");

   // Final wlast of a request meets the last requester word or the flush beat
   a_wlast_valid : assert property (@(posedge clk_i) disable iff (rst_i)
      axi_wlast_o |->
         axi_wvalid_o && (!(last_q && axi_wready_i) || flush || m_wlast_o))
      else $error("wlast without wvalid or request ended with words left");

   a_len_nonzero : assert property (@(posedge clk_i) disable iff (rst_i)
      start |-> m_wlen_i != '0)
      else $error("zero length write request");

   a_bresp_okay : assert property (@(posedge clk_i) disable iff (rst_i)
      axi_bvalid_i |-> axi_bresp_i == 2'b00)
      else $warning("write response %0d is not OKAY", axi_bresp_i);

endmodule

`default_nettype wire

//--- src/axi_data_aligner.sv
`timescale 1ns/10ps
`default_nettype none

module axi_data_aligner #(
   parameter int DATA_W = 32
) (
   input  wire                          clk_i,
   input  wire                          rst_i,
   input  wire [$clog2(DATA_W/8)-1:0]   offset_i,
   input  wire [DATA_W-1:0]             data_i,
   input  wire                          take_i,
   output logic [DATA_W-1:0]            data_o
);

   localparam int SH_W = $clog2(DATA_W) + 1;

   logic [DATA_W-1:0] prev_q;   // Last word taken from the requester
   logic [SH_W-1:0]   hi_sh;
   logic [SH_W-1:0]   lo_sh;

   assign hi_sh = SH_W'({offset_i, 3'b000});
   assign lo_sh = SH_W'(DATA_W) - hi_sh;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         prev_q <= '0;
      end else if (take_i) begin
         prev_q <= data_i;
      end
   end

   // Leftover upper bytes land in the low lanes.
   // With zero offset the shift clears the old word entirely.
   // On a flush beat the data_i part is don't care, strobes mask it.
   assign data_o = (prev_q >> lo_sh) | (data_i << hi_sh);

endmodule

`default_nettype wire

//--- src/axi_burst_planner.sv
`timescale 1ns/10ps
`default_nettype none

module axi_burst_planner #(
   parameter int DATA_W    = 32,
   parameter int MAX_BEATS = 16
) (
   input  wire                     clk_i,
   input  wire                     rst_i,
   input  wire axi_wr_pkg::addr_t  addr_i,
   input  wire axi_wr_pkg::blen_t  len_i,
   input  wire                     start_i,
   input  wire                     burst_accept_i,
   output axi_wr_pkg::addr_t       burst_addr_o,
   output axi_wr_pkg::axlen_t      burst_len_o,
   output logic [DATA_W/8-1:0]     first_strb_o,
   output logic [DATA_W/8-1:0]     final_strb_o,
   output axi_wr_pkg::cnt_t        words_o,
   output logic                    last_burst_o,
   output logic                    last_burst_next_o
);

   localparam int BYTES = DATA_W / 8;
   localparam int OFF_W = $clog2(BYTES);

   axi_wr_pkg::addr_t cur_addr;   // Word aligned
   axi_wr_pkg::cnt_t  beats_left;
   axi_wr_pkg::cnt_t  cur_beats;
   axi_wr_pkg::addr_t nxt_addr;
   axi_wr_pkg::cnt_t  nxt_left;
   axi_wr_pkg::cnt_t  nxt_beats;
   axi_wr_pkg::addr_t end_addr;
   logic [31:0]       span;
   logic [31:0]       word_span;

   // Smallest of beats left, MAX_BEATS and beats up to the 4 KB page end
   function automatic axi_wr_pkg::cnt_t burst_beats(input axi_wr_pkg::addr_t a,
                                                    input axi_wr_pkg::cnt_t  left);
      logic [12:0]      to_page;
      axi_wr_pkg::cnt_t page_beats;
      axi_wr_pkg::cnt_t n;
      to_page    = 13'h1000 - {1'b0, a[11:0]};
      page_beats = axi_wr_pkg::cnt_t'(to_page >> OFF_W);
      n          = left;
      if (n > axi_wr_pkg::cnt_t'(MAX_BEATS)) n = axi_wr_pkg::cnt_t'(MAX_BEATS);
      if (n > page_beats) n = page_beats;
      return n;
   endfunction

   assign span      = 32'(addr_i[OFF_W-1:0]) + 32'(len_i) + 32'(BYTES - 1);
   assign word_span = 32'(len_i) + 32'(BYTES - 1);
   assign end_addr  = addr_i + axi_wr_pkg::addr_t'(len_i) - 32'd1;

   assign cur_beats = burst_beats(cur_addr, beats_left);
   assign nxt_addr  = cur_addr + (axi_wr_pkg::addr_t'(cur_beats) << OFF_W);
   assign nxt_left  = beats_left - cur_beats;
   assign nxt_beats = burst_beats(nxt_addr, nxt_left);

   assign burst_addr_o      = cur_addr;
   assign burst_len_o       = axi_wr_pkg::axlen_t'(cur_beats - axi_wr_pkg::cnt_t'(1));
   assign last_burst_o      = (cur_beats == beats_left);
   assign last_burst_next_o = !last_burst_o && (nxt_beats == nxt_left); // One burst ahead

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         cur_addr   <= '0;
         beats_left <= '0;
      end else if (start_i) begin
         cur_addr   <= addr_i & ~axi_wr_pkg::addr_t'(BYTES - 1);
         beats_left <= axi_wr_pkg::cnt_t'(span >> OFF_W);
      end else if (burst_accept_i) begin
         cur_addr   <= nxt_addr;
         beats_left <= nxt_left;
      end
   end

   // Edge strobes and word count hold for the whole request
   always_ff @(posedge clk_i) begin
      if (start_i) begin
         first_strb_o <= {BYTES{1'b1}} << addr_i[OFF_W-1:0];
         final_strb_o <= {BYTES{1'b1}} >> (~end_addr[OFF_W-1:0]);
         words_o      <= axi_wr_pkg::cnt_t'(word_span >> OFF_W);
      end
   end

   // Accepted burst must end in the page it starts in
   a_no_4k_cross : assert property (@(posedge clk_i) disable iff (rst_i)
      burst_accept_i |->
         ((burst_addr_o + ((axi_wr_pkg::addr_t'(burst_len_o) + 32'd1) << OFF_W) - 32'd1)
            >> 12) == (burst_addr_o >> 12))
      else $error("burst crosses a 4 KB boundary at %h", burst_addr_o);

endmodule

`default_nettype wire

//--- src/axi_wr_pkg.sv
`default_nettype none

package axi_wr_pkg;

   typedef logic [31:0] addr_t;   // Byte address
   typedef logic [15:0] blen_t;   // Request length in bytes
   typedef logic [7:0]  axlen_t;  // AXI burst length field
   typedef logic [15:0] cnt_t;    // Word and beat counters

   localparam logic [1:0] AXI_BURST_INCR = 2'b01;
   localparam logic [3:0] AXI_CACHE_DEF  = 4'h2;   // Normal, non-bufferable
   localparam logic [2:0] AXI_PROT_DEF   = 3'b010; // Unprivileged, non-secure, data

   // AXI size code for a bus of the given width in bits
   function automatic logic [2:0] axsize_enc(input int unsigned width);
      logic [2:0] code;
      case (width)
         16:      code = 3'b001;
         32:      code = 3'b010;
         64:      code = 3'b011;
         128:     code = 3'b100;
         256:     code = 3'b101;
         512:     code = 3'b110;
         1024:    code = 3'b111;
         default: code = 3'b000;
      endcase
      return code;
   endfunction

endpackage

`default_nettype wire
